/* cpu8.f */
design/cpu8_core_pkg.sv
design/cpu8_isa_pkg.sv
design/control_unit.sv
design/alu.sv
design/reg_file.sv
design/pc_unit.sv
design/instr_mem.sv
design/cpu8_top.sv
bench/cpu8_properties.sv
bench/cpu8_tb.sv

/* bench/cpu8_tb.sv */
`timescale 1ns/1ns

module cpu8_tb import cpu8_core_pkg::*; import cpu8_isa_pkg::*; ();

    localparam int imem_depth   = 64;
    localparam int pc_w         = $clog2(imem_depth);
    localparam int reset_cycles = 5;
    localparam int idle_cycles  = 4;
    localparam int prog_words   = 58;  // words loaded over all tests
    localparam int num_tests    = 20;
    localparam int max_cycles   =
        2 * (reset_cycles + idle_cycles + 2 * prog_words + 6 * num_tests);

    logic            clk = 1'b0;
    logic            rst_n;
    logic            run;
    logic            prog_we;
    logic [pc_w-1:0] prog_addr;
    instr_t          prog_data;
    logic            retire;
    logic [pc_w-1:0] pc;
    logic            wb_en;
    reg_idx_t        wb_reg;
    data_t           wb_data;

    logic [31:0] lfsr = 32'h3223;
    instr_t      prog [$];
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    logic        wrote;
    reg_idx_t    last_reg;
    data_t       last_data;

    cpu8_top #(
        .imem_depth (imem_depth)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .retire    (retire),
        .pc        (pc),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic data_t take_bits(int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic data_t alu_rule(opcode_t op, data_t a, data_t b);
        case (op)
            op_add:  return data_t'(a + b);
            op_sub:  return data_t'(a - b);
            op_and:  return a & b;
            op_or:   return a | b;
            op_mult: return data_t'(a * b);
            op_sll:  return data_t'(a << b[2:0]);
            op_srl:  return a >> b[2:0];
            op_sra:  return data_t'($signed(a) >>> b[2:0]);
            op_ror:  return data_t'((a >> b[2:0]) | (a << (8 - b[2:0])));
            default: return b;
        endcase
    endfunction

    function automatic void emit(opcode_t op, data_t d, data_t s1, data_t s2);
        instr_t w;
        w.opcode = op;
        w.dest   = d;
        w.src1   = s1;
        w.src2   = s2;
        prog.push_back(w);
    endfunction

    task automatic test_prog(string name, int n_retire, int pause_at,
                             reg_idx_t exp_reg, data_t exp_data);
        logic [pc_w-1:0] base;
        @(negedge clk);
        base  = pc;  // program goes where the halted pc points
        wrote = 1'b0;
        foreach (prog[i]) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= pc_w'(base + i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        for (int i = 0; i < n_retire; i++) begin
            if (i == pause_at) begin
                run <= 1'b0;  // hold mid-program
                repeat (3) @(posedge clk);
            end
            run <= 1'b1;
            @(negedge clk);
            if (wb_en) begin
                wrote     = 1'b1;
                last_reg  = wb_reg;
                last_data = wb_data;
            end
            @(posedge clk);
        end
        run <= 1'b0;
        tests_run++;
        prog.delete();
        if (!wrote) begin
            tests_failed++;
            $display("test %s wrote no register", name);
        end else if (last_reg != exp_reg || last_data != exp_data) begin
            tests_failed++;
            $display("mismatch at %0t ns: %s wrote r%0d=%h, expected r%0d=%h",
                     $time, name, last_reg, last_data, exp_reg, exp_data);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    initial begin
        data_t   a;
        data_t   b;
        data_t   x;
        data_t   y;
        data_t   imm;
        logic    idle_ok;
        opcode_t arith_ops [5];
        string   arith_names [5];
        opcode_t shift_ops [4];
        string   shift_names [4];
        opcode_t br_op;
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        arith_ops   = '{op_add, op_sub, op_and, op_or, op_mult};
        arith_names = '{"add", "sub", "and", "or", "mult"};
        shift_ops   = '{op_sll, op_srl, op_sra, op_ror};
        shift_names = '{"sll", "srl", "sra", "ror"};
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        idle_ok = 1'b1;
        repeat (idle_cycles) begin
            @(negedge clk);
            idle_ok &= !retire && !wb_en && (pc == '0);
        end
        tests_run++;
        if (idle_ok) begin
            $display("test idle ok");
        end else begin
            tests_failed++;
            $display("test idle saw activity or a moving pc while halted");
        end

        a = take_bits(8);
        emit(op_loadi, 8'd1, 8'd0, a);
        test_prog("loadi", 1, -1, 3'd1, a);
        a = take_bits(8);
        emit(op_loadi, 8'd2, 8'd0, a);
        emit(op_mov, 8'd3, 8'd0, 8'd2);  // copies src2 register
        test_prog("mov", 2, -1, 3'd3, a);

        foreach (arith_ops[i]) begin
            a = take_bits(8);
            b = take_bits(8);
            emit(op_loadi, 8'd1, 8'd0, a);
            emit(op_loadi, 8'd2, 8'd0, b);
            emit(arith_ops[i], 8'd4, 8'd1, 8'd2);
            test_prog(arith_names[i], 3, -1, 3'd4, alu_rule(arith_ops[i], a, b));
        end

        foreach (shift_ops[i]) begin
            a   = take_bits(8) | 8'h81;  // sign bit for sra and low bit so srl and ror differ
            imm = take_bits(8);
            if (imm[2:0] == 3'd0) begin
                imm[2:0] = 3'd5;
            end
            emit(op_loadi, 8'd1, 8'd0, a);
            emit(shift_ops[i], 8'd5, 8'd1, imm);
            test_prog(shift_names[i], 2, -1, 3'd5, alu_rule(shift_ops[i], a, imm));
        end

        x = take_bits(8);
        y = x ^ 8'h5a;
        emit(op_j, 8'd1, 8'd0, 8'd0);
        emit(op_loadi, 8'd6, 8'd0, y);  // skipped
        emit(op_loadi, 8'd6, 8'd0, x);
        test_prog("j forward", 2, -1, 3'd6, x);
        emit(op_j, 8'd1, 8'd0, 8'd0);
        emit(op_loadi, 8'd6, 8'd0, x);
        emit(op_j, 8'hfe, 8'd0, 8'd0);  // back by two
        emit(op_loadi, 8'd6, 8'd0, y);
        test_prog("j backward", 3, -1, 3'd6, x);

        for (int k = 0; k < 4; k++) begin
            br_op = (k < 2) ? op_beq : op_bne;
            a     = take_bits(8);
            b     = k[0] ? a : a ^ 8'h80;  // odd k compares equal values
            emit(op_loadi, 8'd1, 8'd0, a);
            emit(op_loadi, 8'd2, 8'd0, b);
            emit(br_op, 8'd1, 8'd1, 8'd2);
            emit(op_loadi, 8'd6, 8'd0, y);
            emit(op_loadi, 8'd6, 8'd0, x);
            test_prog($sformatf("%s %s", (k < 2) ? "beq" : "bne", k[0] ? "equal" : "unequal"),
                      4, -1, 3'd6, (((k < 2) == k[0]) ? x : y));
        end

        emit(op_loadi, 8'd6, 8'd0, x);
        emit(8'hee, 8'd6, 8'd1, 8'd2);  // not a known opcode
        test_prog("unknown opcode", 2, -1, 3'd6, x);

        a = take_bits(8);
        b = take_bits(8);
        emit(op_loadi, 8'd1, 8'd0, a);
        emit(op_loadi, 8'd2, 8'd0, b);
        emit(op_add, 8'd4, 8'd1, 8'd2);
        test_prog("run hold", 3, 2, 3'd4, alu_rule(op_add, a, b));

        repeat (2) @(posedge clk);
        $display("tests %0d, failed %0d, assertion errors %0d",
                 tests_run, tests_failed, dut0.props0.assert_fails);
        if (tests_failed == 0 && dut0.props0.assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* bench/cpu8_properties.sv */
`timescale 1ns/1ns

module cpu8_properties import cpu8_core_pkg::*; import cpu8_isa_pkg::*; #(
    parameter int imem_depth = 64
) (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          run,
    input logic                          prog_we,
    input logic [$clog2(imem_depth)-1:0] prog_addr,
    input instr_t                        prog_data,
    input logic                          retire,
    input logic [$clog2(imem_depth)-1:0] pc,
    input logic                          wb_en,
    input reg_idx_t                      wb_reg,
    input data_t                         wb_data
);

    localparam int pc_w = $clog2(imem_depth);

    instr_t          shadow_prog [imem_depth];  // copy of what the load port wrote
    data_t           shadow_regs [num_regs];
    logic [pc_w-1:0] shadow_pc;
    logic [pc_w-1:0] exp_next_pc;
    instr_t          cur;
    data_t           op_a;
    data_t           op_b;
    data_t           exp_data;
    logic [2:0]      sh;
    logic            exp_wr;
    logic            exp_taken;
    int              assert_fails = 0;  // read by the testbench at the end

    always_comb begin
        cur  = shadow_prog[shadow_pc];
        op_a = shadow_regs[reg_idx_t'(cur.src1)];
        op_b = shadow_regs[reg_idx_t'(cur.src2)];
        sh   = cur.src2[2:0];
        case (cur.opcode)
            op_add:   exp_data = data_t'(op_a + op_b);
            op_sub:   exp_data = data_t'(op_a - op_b);
            op_and:   exp_data = op_a & op_b;
            op_or:    exp_data = op_a | op_b;
            op_mult:  exp_data = data_t'(op_a * op_b);  // low byte
            op_mov:   exp_data = op_b;
            op_loadi: exp_data = cur.src2;
            op_sll:   exp_data = data_t'(op_a << sh);
            op_srl:   exp_data = op_a >> sh;
            op_sra:   exp_data = data_t'($signed(op_a) >>> sh);
            op_ror:   exp_data = data_t'((op_a >> sh) | (op_a << (8 - sh)));
            default:  exp_data = '0;
        endcase
        exp_taken = (cur.opcode == op_j)
                  | ((cur.opcode == op_beq) & (op_a == op_b))
                  | ((cur.opcode == op_bne) & (op_a != op_b));
        exp_wr = (cur.opcode <= op_ror) & !(cur.opcode inside {op_j, op_beq, op_bne});
        // offset taken modulo the memory depth
        exp_next_pc = exp_taken ? pc_w'(shadow_pc + 1 + cur.dest) : pc_w'(shadow_pc + 1);
    end

    always_ff @(posedge clk) begin
        if (prog_we && !run) begin
            shadow_prog[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow_pc <= '0;
            for (int i = 0; i < num_regs; i++) begin
                shadow_regs[i] <= '0;
            end
        end else if (run) begin
            if (exp_wr) begin
                shadow_regs[reg_idx_t'(cur.dest)] <= exp_data;
            end
            shadow_pc <= exp_next_pc;
        end
    end

    a_halted: assert property (@(posedge clk) !run |-> !retire && !wb_en)
        else begin
            $error("retire or wb_en high while run is low");
            assert_fails++;
        end

    a_retire: assert property (@(posedge clk) disable iff (!rst_n) run |-> retire)
        else begin
            $error("retire low while run is high");
            assert_fails++;
        end

    a_reset_pc: assert property (@(posedge clk) !rst_n |=> pc == '0)
        else begin
            $error("pc not cleared by reset");
            assert_fails++;
        end

    a_hold_pc: assert property (@(posedge clk) disable iff (!rst_n) !run |=> $stable(pc))
        else begin
            $error("pc moved while run is low");
            assert_fails++;
        end

    a_pc: assert property (@(posedge clk) disable iff (!rst_n) pc == shadow_pc)
        else begin
            $error("pc %0d differs from model pc %0d", pc, shadow_pc);
            assert_fails++;
        end

    a_wb_en: assert property (@(posedge clk) disable iff (!rst_n) retire |-> wb_en == exp_wr)
        else begin
            $error("wb_en is %b for opcode %0d", wb_en, cur.opcode);
            assert_fails++;
        end

    a_wb_val: assert property (@(posedge clk) disable iff (!rst_n)
        retire && exp_wr |-> wb_reg == reg_idx_t'(cur.dest) && wb_data == exp_data)
        else begin
            $error("write r%0d=%h, model r%0d=%h", wb_reg, wb_data, cur.dest[2:0], exp_data);
            assert_fails++;
        end

endmodule

bind cpu8_top cpu8_properties #(
    .imem_depth (imem_depth)
) props0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .retire    (retire),
    .pc        (pc),
    .wb_en     (wb_en),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data)
);

/* design/cpu8_top.sv */
`timescale 1ns/1ns

module cpu8_top import cpu8_core_pkg::*; import cpu8_isa_pkg::*; #(
    parameter int imem_depth = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [$clog2(imem_depth)-1:0] prog_addr,
    input  instr_t                        prog_data,
    output logic                          retire,
    output logic [$clog2(imem_depth)-1:0] pc,
    output logic                          wb_en,
    output reg_idx_t                      wb_reg,
    output data_t                         wb_data
);

    instr_t   instr;
    ctrl_t    ctrl;
    data_t    rdata1;
    data_t    rdata2;
    data_t    alu_result;
    logic     alu_zero;
    logic     imem_we;
    logic     rf_we;
    reg_idx_t dest_idx;

    assign imem_we  = prog_we & ~run;  // program load only while halted
    assign rf_we    = ctrl.write_en & run;
    assign dest_idx = instr.dest[reg_idx_w-1:0];

    instr_mem #(
        .imem_depth (imem_depth)
    ) u_imem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (pc),
        .rdata (instr)
    );

    control_unit u_ctrl (
        .opcode (instr.opcode),
        .ctrl   (ctrl)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (rf_we),
        .waddr  (dest_idx),
        .wdata  (alu_result),
        .raddr1 (instr.src1[reg_idx_w-1:0]),
        .raddr2 (instr.src2[reg_idx_w-1:0]),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu u_alu (
        .op           (ctrl.alu_op),
        .negate       (ctrl.negate),
        .use_reg_src2 (ctrl.use_reg_src2),
        .a            (rdata1),
        .b_reg        (rdata2),
        .imm          (instr.src2),
        .result       (alu_result),
        .zero         (alu_zero)
    );

    pc_unit #(
        .imem_depth (imem_depth)
    ) u_pc (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .ctrl   (ctrl),
        .zero   (alu_zero),
        .offset (instr.dest),  // dest byte holds the branch offset
        .pc     (pc)
    );

    // one instruction retires per cycle while run is high
    assign retire  = run;
    assign wb_en   = rf_we;
    assign wb_reg  = dest_idx;
    assign wb_data = alu_result;

endmodule

/* design/instr_mem.sv */
`timescale 1ns/1ns

module instr_mem import cpu8_isa_pkg::*; #(
    parameter int imem_depth = 64
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(imem_depth)-1:0] waddr,
    input  instr_t                        wdata,
    input  logic [$clog2(imem_depth)-1:0] raddr,
    output instr_t                        rdata
);

    instr_t mem [imem_depth];  // contents undefined until loaded

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];  // async read at the pc

endmodule

/* design/pc_unit.sv */
`timescale 1ns/1ns

module pc_unit import cpu8_core_pkg::*; import cpu8_isa_pkg::*; #(
    parameter int imem_depth = 64  // power of two, pc wraps on overflow
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  ctrl_t                         ctrl,
    input  logic                          zero,
    input  data_t                         offset,
    output logic [$clog2(imem_depth)-1:0] pc
);

    localparam int pc_w = $clog2(imem_depth);

    logic [pc_w-1:0] pc_seq;
    logic [pc_w-1:0] pc_target;
    logic [pc_w-1:0] offset_ext;
    logic            taken;

    // offset counts instructions, relative to pc + 1
    assign offset_ext = pc_w'($signed(offset));
    assign pc_seq     = pc + 1'b1;
    assign pc_target  = pc_seq + offset_ext;

    assign taken = ctrl.jump
                 | (ctrl.branch_eq & zero)
                 | (ctrl.branch_ne & ~zero);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= taken ? pc_target : pc_seq;
        end
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ns

module reg_file import cpu8_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  reg_idx_t waddr,
    input  data_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output data_t    rdata1,
    output data_t    rdata2
);

    data_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass, a read in the write cycle returns the old value
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

/* design/alu.sv */
`timescale 1ns/1ns

module alu import cpu8_core_pkg::*; (
    input  alu_op_e op,
    input  logic    negate,
    input  logic    use_reg_src2,
    input  data_t   a,
    input  data_t   b_reg,
    input  data_t   imm,
    output data_t   result,
    output logic    zero
);

    data_t      b_sel;   // operand 2 before negation
    data_t      b_op;    // operand 2 as seen by the operation
    logic [2:0] shamt;

    assign b_sel = use_reg_src2 ? b_reg : imm;
    assign b_op  = negate ? data_t'(~b_sel + 8'd1) : b_sel;
    assign shamt = imm[2:0];  // shifts only use 3 bits

    always_comb begin
        case (op)
            alu_fwd: begin
                result = b_op;
            end
            alu_add: begin
                result = data_t'(a + b_op);  // wraps
            end
            alu_and: begin
                result = a & b_op;
            end
            alu_or: begin
                result = a | b_op;
            end
            alu_mul: begin
                result = data_t'(a * b_op);  // low byte only
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = data_t'($signed(a) >>> shamt);  // keeps sign bit
            end
            alu_ror: begin
                result = data_t'({a, a} >> shamt);  // low byte of doubled word
            end
            default: begin
                result = b_op;
            end
        endcase
    end

    // branch compare uses this after a - b
    assign zero = (result == '0);

endmodule

/* design/control_unit.sv */
`timescale 1ns/1ns

module control_unit import cpu8_core_pkg::*; import cpu8_isa_pkg::*; (
    input  opcode_t opcode,
    output ctrl_t   ctrl
);

    always_comb begin
        ctrl        = '0;  // unknown opcodes fall through as a no-op
        ctrl.alu_op = alu_fwd;
        case (opcode)
            op_add: begin
                ctrl.write_en     = 1'b1;
                ctrl.alu_op       = alu_add;
                ctrl.use_reg_src2 = 1'b1;
            end
            op_sub: begin
                ctrl.write_en     = 1'b1;
                ctrl.alu_op       = alu_add;
                ctrl.use_reg_src2 = 1'b1;
                ctrl.negate       = 1'b1;  // src1 + (-src2)
            end
            op_and: begin
                ctrl.write_en     = 1'b1;
                ctrl.alu_op       = alu_and;
                ctrl.use_reg_src2 = 1'b1;
            end
            op_or: begin
                ctrl.write_en     = 1'b1;
                ctrl.alu_op       = alu_or;
                ctrl.use_reg_src2 = 1'b1;
            end
            op_mov: begin
                ctrl.write_en     = 1'b1;  // copies register src2
                ctrl.use_reg_src2 = 1'b1;
            end
            op_loadi: begin
                ctrl.write_en = 1'b1;  // forwards the immediate
            end
            op_j: begin
                ctrl.jump = 1'b1;
            end
            op_beq: begin
                ctrl.alu_op       = alu_add;
                ctrl.use_reg_src2 = 1'b1;
                ctrl.negate       = 1'b1;
                ctrl.branch_eq    = 1'b1;
            end
            op_bne: begin
                ctrl.alu_op       = alu_add;
                ctrl.use_reg_src2 = 1'b1;
                ctrl.negate       = 1'b1;
                ctrl.branch_ne    = 1'b1;
            end
            op_mult: begin
                ctrl.write_en     = 1'b1;
                ctrl.alu_op       = alu_mul;
                ctrl.use_reg_src2 = 1'b1;
            end
            // shift amount comes from the immediate byte
            op_sll: begin
                ctrl.write_en = 1'b1;
                ctrl.alu_op   = alu_sll;
            end
            op_srl: begin
                ctrl.write_en = 1'b1;
                ctrl.alu_op   = alu_srl;
            end
            op_sra: begin
                ctrl.write_en = 1'b1;
                ctrl.alu_op   = alu_sra;
            end
            op_ror: begin
                ctrl.write_en = 1'b1;
                ctrl.alu_op   = alu_ror;
            end
            default: begin
                ctrl.write_en = 1'b0;
            end
        endcase
    end

endmodule

/* design/cpu8_isa_pkg.sv */
package cpu8_isa_pkg;

    import cpu8_core_pkg::*;

    typedef logic [7:0] opcode_t;

    localparam opcode_t op_add   = 8'd0;
    localparam opcode_t op_sub   = 8'd1;
    localparam opcode_t op_and   = 8'd2;
    localparam opcode_t op_or    = 8'd3;
    localparam opcode_t op_mov   = 8'd4;
    localparam opcode_t op_loadi = 8'd5;
    localparam opcode_t op_j     = 8'd6;
    localparam opcode_t op_beq   = 8'd7;
    localparam opcode_t op_bne   = 8'd8;
    localparam opcode_t op_mult  = 8'd9;
    localparam opcode_t op_sll   = 8'd10;
    localparam opcode_t op_srl   = 8'd11;
    localparam opcode_t op_sra   = 8'd12;
    localparam opcode_t op_ror   = 8'd13;

    // instruction word, opcode in the top byte
    typedef struct packed {
        opcode_t opcode;
        data_t   dest;  // dest register, or signed offset for j/beq/bne
        data_t   src1;
        data_t   src2;  // register index or immediate
    } instr_t;

    // decoded control flags
    typedef struct packed {
        logic    write_en;
        alu_op_e alu_op;
        logic    use_reg_src2;  // 1 = register, 0 = immediate byte
        logic    negate;        // two's complement of operand 2
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

endpackage

/* design/cpu8_core_pkg.sv */
package cpu8_core_pkg;

    localparam int data_w   = 8;
    localparam int num_regs = 8;
    localparam int reg_idx_w = $clog2(num_regs);

    // one data word, all results wrap to this width
    typedef logic [data_w-1:0] data_t;

    // register index, taken from the low bits of a register byte
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // each operation has its own code, srl and ror are distinct
    typedef enum logic [3:0] {
        alu_fwd = 4'd0,  // pass operand 2
        alu_add = 4'd1,  // also used by sub, beq, bne with negate
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_mul = 4'd4,  // low byte of product
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_sra = 4'd7,
        alu_ror = 4'd8
    } alu_op_e;

endpackage
